// ==== hw/rv_fe_pkg.sv ====
// RISC-V front end package with shared types, opcode constants and field decoders
package rv_fe_pkg;

  ////////////////////////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////////////////////////

  // Address or program counter
  typedef logic [31:0] xlen_t;
  // One instruction word
  typedef logic [31:0] instr_t;
  // Register file address
  typedef logic [4:0]  rsd_t;
  typedef logic [6:0]  opcode_t;
  // Prediction bits, bit 1 set means taken
  typedef logic [1:0]  bp_t;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // addi x0,x0,0
  localparam instr_t  INSTR_NOP  = 32'h0000_0013;

  // Counter reset value, weakly not taken
  localparam bp_t     BP_WEAK_NT = 2'b01;
  // Static prediction for JAL
  localparam bp_t     BP_JAL     = 2'b10;

  // AXI response and protection encodings
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
  // Unprivileged, secure, instruction access
  localparam logic [2:0] AXI_PROT_INSN = 3'b100;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    instr_t instr;
    logic   bubble;
  } instruction_t;

  typedef struct packed {
    logic bus_error;
    logic misaligned;
  } exceptions_t;

  // Stage word from fetch into pre-decode
  typedef struct packed {
    xlen_t        pc;
    instruction_t insn;
    exceptions_t  exc;
    bp_t          bp;
  } fetch_t;

  // AXI4-Lite read address channel payload
  typedef struct packed {
    xlen_t      addr;
    logic [2:0] prot;
  } axil_ar_t;

  // AXI4-Lite read data channel payload
  typedef struct packed {
    instr_t     data;
    logic [1:0] resp;
  } axil_r_t;

  ////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////

  function automatic opcode_t decode_opcode(instr_t instr);
    return instr[6:0];
  endfunction

  function automatic rsd_t decode_rs1(instr_t instr);
    return instr[19:15];
  endfunction

  function automatic rsd_t decode_rs2(instr_t instr);
    return instr[24:20];
  endfunction

  // J-type immediate, sign extended
  function automatic xlen_t decode_imm_j(instr_t instr);
    return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

  // B-type immediate, sign extended
  function automatic xlen_t decode_imm_b(instr_t instr);
    return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  endfunction

endpackage

// ==== hw/rv_fetch.sv ====
// Instruction fetch unit, AXI4-Lite read master with two reads in flight and a word buffer
`timescale 1ns/1ps

module rv_fetch import rv_fe_pkg::*; #(
  parameter xlen_t PC_INIT = 'h200
) (
  input  logic     clk_i,
  input  logic     rst_ni,

  output axil_ar_t ar_o,
  output logic     arvalid_o,
  input  logic     arready_i,
  input  axil_r_t  r_i,
  input  logic     rvalid_i,
  output logic     rready_o,

  output xlen_t    bht_pc_o,
  input  bp_t      bht_bp_i,

  input  logic     st_flush_i,
  input  xlen_t    tr_vec_i,
  input  logic     bu_flush_i,
  input  xlen_t    bu_nxt_pc_i,
  input  logic     pd_latch_nxt_pc_i,
  input  xlen_t    pd_nxt_pc_i,

  input  logic     pd_stall_i,
  output fetch_t   fe_o
);

  typedef logic [1:0] cnt_t;

  // Request side
  xlen_t  pc_q, pc_d, pc_src, redir_pc;
  xlen_t  ar_addr_q, ar_addr_d;
  logic   arvalid_q, arvalid_d;
  logic   ar_fire, r_fire, redirect, keep_head;
  logic   [2:0] slots;

  // Counters of reads and buffer words
  cnt_t   inflight_q, inflight_d;
  cnt_t   discard_q, discard_d;
  cnt_t   fill_q, fill_d;

  // Per-read record, oldest read at tag_rd_q
  xlen_t  tag_pc [2];
  bp_t    tag_bp [2];
  logic   tag_wr_q, tag_rd_q;
  logic   bp_pend_q, bp_idx_q;
  bp_t    rsp_bp;

  // Instruction buffer
  fetch_t fb_q [2];
  logic   wr_ptr_q, wr_ptr_d, rd_ptr_q, rd_ptr_d;
  logic   push, pop;

  ////////////////////////////////////////////////////////////
  // Handshakes and redirect selection
  ////////////////////////////////////////////////////////////

  assign ar_fire  = arvalid_q & arready_i;
  assign r_fire   = rvalid_i & rready_o;
  assign redirect = st_flush_i | bu_flush_i | pd_latch_nxt_pc_i;

  // Trap wins over branch unit, branch unit over predictor
  assign redir_pc = st_flush_i ? tr_vec_i    :
                    bu_flush_i ? bu_nxt_pc_i :
                                 pd_nxt_pc_i;

  // Predicted jump still on fe_o while stalled stays in the buffer
  assign keep_head = pd_latch_nxt_pc_i & ~st_flush_i & ~bu_flush_i &
                     pd_stall_i & (fill_q != 2'd0);

  assign pop  = ~pd_stall_i & (fill_q != 2'd0);
  // Responses of reads issued before a redirect never enter the buffer
  assign push = r_fire & (discard_q == 2'd0) & ~redirect;

  // Room for every read in flight that will be kept
  assign rready_o = (3'(fill_q) + 3'(inflight_q) - 3'(discard_q)) <= 3'd2;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    inflight_d = inflight_q + cnt_t'(ar_fire) - cnt_t'(r_fire);

    // Everything already requested becomes stale on a redirect
    if (redirect) begin
      discard_d = inflight_q - cnt_t'(r_fire) + cnt_t'(arvalid_q);
    end else if (r_fire && discard_q != 2'd0) begin
      discard_d = discard_q - 2'd1;
    end else begin
      discard_d = discard_q;
    end

    rd_ptr_d = rd_ptr_q;
    if (redirect) begin
      fill_d   = cnt_t'(keep_head);
      wr_ptr_d = keep_head ? ~rd_ptr_q : rd_ptr_q;
    end else begin
      fill_d   = fill_q + cnt_t'(push) - cnt_t'(pop);
      wr_ptr_d = wr_ptr_q ^ push;
      rd_ptr_d = rd_ptr_q ^ pop;
    end

    // Reads plus buffered words stay within two
    slots  = 3'(inflight_d) + 3'(fill_d);
    pc_src = redirect ? redir_pc : pc_q;

    if (arvalid_q && !arready_i) begin
      // Address held stable until the slave accepts it
      arvalid_d = 1'b1;
      ar_addr_d = ar_addr_q;
      pc_d      = pc_src;
    end else begin
      arvalid_d = slots < 3'd2;
      ar_addr_d = pc_src;
      pc_d      = arvalid_d ? pc_src + 32'd4 : pc_src;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q       <= PC_INIT;
      ar_addr_q  <= PC_INIT;
      arvalid_q  <= 1'b0;
      inflight_q <= 2'd0;
      discard_q  <= 2'd0;
      fill_q     <= 2'd0;
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
      tag_wr_q   <= 1'b0;
      tag_rd_q   <= 1'b0;
      bp_pend_q  <= 1'b0;
      bp_idx_q   <= 1'b0;
    end else begin
      pc_q       <= pc_d;
      ar_addr_q  <= ar_addr_d;
      arvalid_q  <= arvalid_d;
      inflight_q <= inflight_d;
      discard_q  <= discard_d;
      fill_q     <= fill_d;
      wr_ptr_q   <= wr_ptr_d;
      rd_ptr_q   <= rd_ptr_d;
      tag_wr_q   <= tag_wr_q ^ ar_fire;
      tag_rd_q   <= tag_rd_q ^ r_fire;
      // BHT answers one cycle after the address
      bp_pend_q  <= ar_fire;
      bp_idx_q   <= tag_wr_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read records and buffer storage
  ////////////////////////////////////////////////////////////

  // Prediction not yet stored when the response follows its AR directly
  assign rsp_bp = (bp_pend_q && bp_idx_q == tag_rd_q) ? bht_bp_i : tag_bp[tag_rd_q];

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      tag_pc[tag_wr_q] <= ar_addr_q;
    end
    if (bp_pend_q) begin
      tag_bp[bp_idx_q] <= bht_bp_i;
    end
    if (push) begin
      fb_q[wr_ptr_q].pc              <= tag_pc[tag_rd_q];
      fb_q[wr_ptr_q].insn.instr      <= r_i.data;
      fb_q[wr_ptr_q].insn.bubble     <= 1'b0;
      fb_q[wr_ptr_q].exc.bus_error   <= r_i.resp != AXI_RESP_OKAY;
      fb_q[wr_ptr_q].exc.misaligned  <= tag_pc[tag_rd_q][1:0] != 2'b00;
      fb_q[wr_ptr_q].bp              <= rsp_bp;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign ar_o.addr = ar_addr_q;
  assign ar_o.prot = AXI_PROT_INSN;
  assign arvalid_o = arvalid_q;
  assign bht_pc_o  = ar_addr_q;

  // Empty buffer shows a bubble at the next fetch address
  always_comb begin
    if (fill_q != 2'd0) begin
      fe_o = fb_q[rd_ptr_q];
    end else begin
      fe_o             = '0;
      fe_o.pc          = pc_q;
      fe_o.insn.instr  = INSTR_NOP;
      fe_o.insn.bubble = 1'b1;
    end
  end

endmodule

// ==== hw/rv_bht.sv ====
// Branch history table of 2-bit saturating counters indexed by the fetch PC
`timescale 1ns/1ps

module rv_bht import rv_fe_pkg::*; #(
  parameter int unsigned BHT_DEPTH = 64
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  input  xlen_t rd_pc_i,
  output bp_t   rd_bp_o,

  input  logic  upd_i,
  input  xlen_t upd_pc_i,
  input  logic  upd_taken_i
);

  localparam int unsigned IDX_W = $clog2(BHT_DEPTH);

  typedef logic [IDX_W-1:0] bht_idx_t;

  bp_t      cnt_q [BHT_DEPTH];
  bp_t      rd_bp_q;
  bp_t      upd_val;
  bht_idx_t rd_idx, upd_idx;

  // One step toward the outcome, saturating at both ends
  function automatic bp_t sat_step(bp_t cnt, logic taken);
    bp_t res;
    res = cnt;
    if (taken && cnt != 2'b11) begin
      res = cnt + 2'b01;
    end else if (!taken && cnt != 2'b00) begin
      res = cnt - 2'b01;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Index and update value
  ////////////////////////////////////////////////////////////

  // Word address bits, byte offset dropped
  assign rd_idx  = rd_pc_i[IDX_W+1:2];
  assign upd_idx = upd_pc_i[IDX_W+1:2];
  assign upd_val = sat_step(cnt_q[upd_idx], upd_taken_i);

  ////////////////////////////////////////////////////////////
  // Counter array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BHT_DEPTH; i++) begin
        cnt_q[i] <= BP_WEAK_NT;
      end
    end else if (upd_i) begin
      cnt_q[upd_idx] <= upd_val;
    end
  end

  // Registered read, same-cycle update forwarded
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_bp_q <= BP_WEAK_NT;
    end else if (upd_i && upd_idx == rd_idx) begin
      rd_bp_q <= upd_val;
    end else begin
      rd_bp_q <= cnt_q[rd_idx];
    end
  end

  assign rd_bp_o = rd_bp_q;

endmodule

// ==== hw/rv_predecode.sv ====
// Instruction pre-decoder with stage registers, register addresses and jump prediction
`timescale 1ns/1ps

module rv_predecode import rv_fe_pkg::*; #(
  parameter xlen_t PC_INIT = 'h200,
  parameter bit    HAS_BPU = 1'b1
) (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         id_stall_i,
  output logic         pd_stall_o,

  input  logic         bu_flush_i,
  input  logic         st_flush_i,
  output logic         pd_flush_o,

  input  xlen_t        bu_nxt_pc_i,
  input  xlen_t        st_nxt_pc_i,

  input  fetch_t       fe_i,

  output rsd_t         pd_rs1_o,
  output rsd_t         pd_rs2_o,

  output xlen_t        pd_nxt_pc_o,
  output logic         pd_latch_nxt_pc_o,
  output bp_t          pd_bp_predict_o,

  output xlen_t        pd_pc_o,
  output instruction_t pd_insn_o,
  output exceptions_t  pd_exceptions_o
);

  xlen_t ext_imm_j, ext_imm_b;
  bp_t   bp_sel;
  logic  taken, taken_q;

  // Either flush empties the stage
  assign pd_flush_o = bu_flush_i | st_flush_i;
  assign pd_stall_o = id_stall_i;

  // Register file addresses straight from the fetch word
  assign pd_rs1_o = decode_rs1(fe_i.insn.instr);
  assign pd_rs2_o = decode_rs2(fe_i.insn.instr);

  ////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_pc_o <= PC_INIT;
    end else if (st_flush_i) begin
      pd_pc_o <= st_nxt_pc_i;
    end else if (bu_flush_i) begin
      pd_pc_o <= bu_nxt_pc_i;
    end else if (!id_stall_i) begin
      pd_pc_o <= fe_i.pc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_insn_o.instr <= INSTR_NOP;
      pd_bp_predict_o <= 2'b00;
    end else if (!id_stall_i) begin
      pd_insn_o.instr <= fe_i.insn.instr;
      pd_bp_predict_o <= bp_sel;
    end
  end

  // Flush overrides the stall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pd_insn_o.bubble <= 1'b1;
      pd_exceptions_o  <= '0;
    end else if (pd_flush_o) begin
      pd_insn_o.bubble <= 1'b1;
      pd_exceptions_o  <= '0;
    end else if (!id_stall_i) begin
      pd_insn_o.bubble <= fe_i.insn.bubble;
      pd_exceptions_o  <= fe_i.exc;
    end
  end

  ////////////////////////////////////////////////////////////
  // Jump and branch prediction
  ////////////////////////////////////////////////////////////

  assign ext_imm_j = decode_imm_j(fe_i.insn.instr);
  assign ext_imm_b = decode_imm_b(fe_i.insn.instr);

  always_comb begin
    taken       = 1'b0;
    bp_sel      = 2'b00;
    pd_nxt_pc_o = fe_i.pc;
    if (!fe_i.insn.bubble) begin
      case (decode_opcode(fe_i.insn.instr))
        OPC_JAL: begin
          taken       = 1'b1;
          bp_sel      = BP_JAL;
          pd_nxt_pc_o = fe_i.pc + ext_imm_j;
        end
        OPC_BRANCH: begin
          // Without a BPU, backward taken and forward not taken
          if (HAS_BPU) begin
            taken  = fe_i.bp[1];
            bp_sel = fe_i.bp;
          end else begin
            taken  = ext_imm_b[31];
            bp_sel = {ext_imm_b[31], 1'b0};
          end
          pd_nxt_pc_o = fe_i.pc + ext_imm_b;
        end
        default: begin
          taken = 1'b0;
        end
      endcase
    end
  end

  // Word held under stall remembers its strobe, a consumed word clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= 1'b0;
    end else begin
      taken_q <= taken & id_stall_i;
    end
  end

  // One pulse per taken jump, held word does not retrigger
  assign pd_latch_nxt_pc_o = taken & ~taken_q;

endmodule

// ==== hw/rv_frontend_top.sv ====
// Instruction front end top level joining fetch, BHT and pre-decode
`timescale 1ns/1ps

module rv_frontend_top import rv_fe_pkg::*; #(
  parameter xlen_t       PC_INIT   = 'h200,
  parameter bit          HAS_BPU   = 1'b1,
  parameter int unsigned BHT_DEPTH = 64
) (
  input  logic         clk_i,
  input  logic         rst_ni,

  // AXI4-Lite read channels
  output axil_ar_t     ar_o,
  output logic         arvalid_o,
  input  logic         arready_i,
  input  axil_r_t      r_i,
  input  logic         rvalid_i,
  output logic         rready_o,

  // Decode stall
  input  logic         id_stall_i,

  // Branch resolution
  input  logic         bu_flush_i,
  input  xlen_t        bu_nxt_pc_i,
  input  logic         bu_upd_i,
  input  xlen_t        bu_upd_pc_i,
  input  logic         bu_taken_i,

  // Trap redirect
  input  logic         st_flush_i,
  input  xlen_t        tr_vec_i,

  // Pre-decode stage outputs
  output logic         pd_stall_o,
  output logic         pd_flush_o,
  output rsd_t         pd_rs1_o,
  output rsd_t         pd_rs2_o,
  output xlen_t        pd_nxt_pc_o,
  output logic         pd_latch_nxt_pc_o,
  output bp_t          pd_bp_predict_o,
  output xlen_t        pd_pc_o,
  output instruction_t pd_insn_o,
  output exceptions_t  pd_exceptions_o
);

  fetch_t fe;
  xlen_t  bht_pc;
  bp_t    bht_bp;

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////

  rv_fetch #(
    .PC_INIT (PC_INIT)
  ) u_fetch (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ar_o              (ar_o),
    .arvalid_o         (arvalid_o),
    .arready_i         (arready_i),
    .r_i               (r_i),
    .rvalid_i          (rvalid_i),
    .rready_o          (rready_o),
    .bht_pc_o          (bht_pc),
    .bht_bp_i          (bht_bp),
    .st_flush_i        (st_flush_i),
    .tr_vec_i          (tr_vec_i),
    .bu_flush_i        (bu_flush_i),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .pd_latch_nxt_pc_i (pd_latch_nxt_pc_o),
    .pd_nxt_pc_i       (pd_nxt_pc_o),
    .pd_stall_i        (pd_stall_o),
    .fe_o              (fe)
  );

  // Prediction counters
  rv_bht #(
    .BHT_DEPTH (BHT_DEPTH)
  ) u_bht (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_pc_i     (bht_pc),
    .rd_bp_o     (bht_bp),
    .upd_i       (bu_upd_i),
    .upd_pc_i    (bu_upd_pc_i),
    .upd_taken_i (bu_taken_i)
  );

  ////////////////////////////////////////////////////////////
  // Pre-decode
  ////////////////////////////////////////////////////////////

  rv_predecode #(
    .PC_INIT (PC_INIT),
    .HAS_BPU (HAS_BPU)
  ) u_predecode (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_stall_i        (id_stall_i),
    .pd_stall_o        (pd_stall_o),
    .bu_flush_i        (bu_flush_i),
    .st_flush_i        (st_flush_i),
    .pd_flush_o        (pd_flush_o),
    .bu_nxt_pc_i       (bu_nxt_pc_i),
    .st_nxt_pc_i       (tr_vec_i),
    .fe_i              (fe),
    .pd_rs1_o          (pd_rs1_o),
    .pd_rs2_o          (pd_rs2_o),
    .pd_nxt_pc_o       (pd_nxt_pc_o),
    .pd_latch_nxt_pc_o (pd_latch_nxt_pc_o),
    .pd_bp_predict_o   (pd_bp_predict_o),
    .pd_pc_o           (pd_pc_o),
    .pd_insn_o         (pd_insn_o),
    .pd_exceptions_o   (pd_exceptions_o)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime PERIOD     = 100ns,
  parameter int      RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== test/tb_axil_rom.sv ====
// AXI4-Lite read-only instruction memory model with random delays and one error word
`timescale 1ns/1ps

module tb_axil_rom import rv_fe_pkg::*; #(
  parameter int unsigned DEPTH   = 256,
  parameter int unsigned ERR_IDX = 144
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  axil_ar_t ar_i,
  input  logic     arvalid_i,
  output logic     arready_o,
  output axil_r_t  r_o,
  output logic     rvalid_o,
  input  logic     rready_i,
  // Random enables for each channel
  input  logic     ar_ok_i,
  input  logic     r_ok_i
);

  // Filled by the testbench top before reset
  instr_t      mem [DEPTH];
  xlen_t       pend_q [$];
  logic [2:0]  pend_cnt;
  logic [7:0]  rsp_idx;

  // At most four reads waiting or being answered
  assign arready_o = ar_ok_i && (pend_cnt < 3'd4);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q.delete();
      pend_cnt <= 3'd0;
      rvalid_o <= 1'b0;
      r_o      <= '0;
    end else begin
      // Response held until the master takes it
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end else if (!rvalid_o && pend_q.size() != 0 && r_ok_i) begin
        rsp_idx  = pend_q[0][9:2];
        rvalid_o <= 1'b1;
        r_o.data <= mem[rsp_idx];
        // SLVERR on the error word
        r_o.resp <= (rsp_idx == ERR_IDX) ? 2'b10 : 2'b00;
        void'(pend_q.pop_front());
      end
      if (arvalid_i && arready_o) begin
        pend_q.push_back(ar_i.addr);
      end
      pend_cnt <= pend_cnt + 3'(arvalid_i && arready_o) - 3'(rvalid_o && rready_i);
    end
  end

endmodule

// ==== test/tb_rv_frontend.sv ====
// Testbench for the instruction front end with program flow model and assertions
`timescale 1ns/1ps

module tb_rv_frontend import rv_fe_pkg::*; #(
  parameter bit HAS_BPU = 1'b1
) ();

  localparam xlen_t       PC_INIT        = 'h200;
  localparam int unsigned ERR_IDX        = 144;
  localparam int          RUN_CYCLES     = 2500;
  localparam int          DRAIN_CYCLES   = 100;
  // Run plus drain plus margin
  localparam int          TIMEOUT_CYCLES = 3000;

  logic clk, rst_n;

  axil_ar_t     ar_o;
  axil_r_t      r_i;
  logic         arvalid_o, arready_i, rvalid_i, rready_o, ar_ok, r_ok;
  logic         id_stall_i, bu_flush_i, bu_upd_i, bu_taken_i, st_flush_i;
  xlen_t        bu_nxt_pc_i, bu_upd_pc_i, tr_vec_i;
  logic         pd_stall_o, pd_flush_o, pd_latch_nxt_pc_o;
  rsd_t         pd_rs1_o, pd_rs2_o;
  xlen_t        pd_nxt_pc_o, pd_pc_o;
  bp_t          pd_bp_predict_o;
  instruction_t pd_insn_o;
  exceptions_t  pd_exceptions_o;

  // Reference data, kind 0 ALU, 1 JAL, 2 branch
  instr_t      rom_mem [256];
  logic [1:0]  kind_tab [256];
  xlen_t       off_tab [256];
  bp_t         bht_cnt [64];
  bp_t         snap [256];
  logic [31:0] rng_state = 32'h34c3_9288;

  xlen_t  exp_pc;
  bp_t    exp_bp;
  instr_t exp_word;
  logic   consume, ar_seen;
  int     mismatches, other_errors, cycles, consumed, err_seen;

  tb_clk_gen #(.PERIOD(100ns), .RST_CYCLES(2)) clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  tb_axil_rom #(.DEPTH(256), .ERR_IDX(ERR_IDX)) rom_i (
    .clk_i (clk), .rst_ni (rst_n),
    .ar_i (ar_o), .arvalid_i (arvalid_o), .arready_o (arready_i),
    .r_o (r_i), .rvalid_o (rvalid_i), .rready_i (rready_o),
    .ar_ok_i (ar_ok), .r_ok_i (r_ok)
  );

  rv_frontend_top #(
    .PC_INIT (PC_INIT), .HAS_BPU (HAS_BPU), .BHT_DEPTH (64)
  ) rv_frontend_top_i (
    .clk_i (clk), .rst_ni (rst_n),
    .ar_o (ar_o), .arvalid_o (arvalid_o), .arready_i (arready_i),
    .r_i (r_i), .rvalid_i (rvalid_i), .rready_o (rready_o),
    .id_stall_i (id_stall_i),
    .bu_flush_i (bu_flush_i), .bu_nxt_pc_i (bu_nxt_pc_i),
    .bu_upd_i (bu_upd_i), .bu_upd_pc_i (bu_upd_pc_i), .bu_taken_i (bu_taken_i),
    .st_flush_i (st_flush_i), .tr_vec_i (tr_vec_i),
    .pd_stall_o (pd_stall_o), .pd_flush_o (pd_flush_o),
    .pd_rs1_o (pd_rs1_o), .pd_rs2_o (pd_rs2_o),
    .pd_nxt_pc_o (pd_nxt_pc_o), .pd_latch_nxt_pc_o (pd_latch_nxt_pc_o),
    .pd_bp_predict_o (pd_bp_predict_o), .pd_pc_o (pd_pc_o),
    .pd_insn_o (pd_insn_o), .pd_exceptions_o (pd_exceptions_o)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic instr_t encode_jal(xlen_t o);
    return {o[20], o[10:1], o[11], o[19:12], 5'd1, 7'b1101111};
  endfunction

  function automatic instr_t encode_branch(xlen_t o, rsd_t rs1, rsd_t rs2);
    return {o[12], o[10:5], rs2, rs1, 3'b001, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic bp_t counter_step(bp_t c, logic t);
    if (t) return (c == 2'b11) ? c : c + 2'b01;
    return (c == 2'b00) ? c : c - 2'b01;
  endfunction

  task automatic report_mismatch(string msg);
    mismatches++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic report_failure(string msg);
    other_errors++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  // ALU words everywhere, jumps sprinkled outside the start block
  task automatic fill_rom();
    logic [31:0] r, s;
    xlen_t mag;
    for (int i = 0; i < 256; i++) begin
      r = next_rand();
      s = next_rand();
      mag = xlen_t'((4 + s[7:4] % 13) * 4);
      off_tab[i]  = s[8] ? -mag : mag;
      kind_tab[i] = 2'd0;
      rom_mem[i]  = {r[31:7] ^ 25'(i * 4), 7'b0110011};
      if (i < 128 || i > 152) begin
        if (s[3:0] == 4'd0) begin
          kind_tab[i] = 2'd1;
          rom_mem[i]  = encode_jal(off_tab[i]);
        end else if (s[3:0] < 4'd4) begin
          kind_tab[i] = 2'd2;
          rom_mem[i]  = encode_branch(off_tab[i], r[19:15], r[24:20]);
        end
      end
      rom_i.mem[i] = rom_mem[i];
      snap[i]      = 2'b01;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  assign consume  = !pd_insn_o.bubble && !id_stall_i;
  assign exp_word = rom_mem[pd_pc_o[9:2]];
  // JAL always taken, branch from counters or offset sign
  assign exp_bp   = (kind_tab[pd_pc_o[9:2]] == 2'd1) ? 2'b10 :
                    HAS_BPU ? snap[pd_pc_o[9:2]] : {off_tab[pd_pc_o[9:2]][31], 1'b0};

  always @(posedge clk or negedge rst_n) begin
    logic [7:0] idx;
    logic tk;
    if (!rst_n) begin
      exp_pc  = PC_INIT;
      ar_seen = 1'b0;
      for (int i = 0; i < 64; i++) bht_cnt[i] = 2'b01;
    end else begin
      // Counter update lands before a same-cycle read
      if (bu_upd_i) begin
        bht_cnt[bu_upd_pc_i[7:2]] = counter_step(bht_cnt[bu_upd_pc_i[7:2]], bu_taken_i);
      end
      if (arvalid_o) ar_seen = 1'b1;
      if (arvalid_o && arready_i) snap[ar_o.addr[9:2]] = bht_cnt[ar_o.addr[7:2]];
      if (consume) begin
        idx = pd_pc_o[9:2];
        consumed++;
        if (idx == ERR_IDX) err_seen++;
        tk = HAS_BPU ? snap[idx][1] : off_tab[idx][31];
        if (kind_tab[idx] == 2'd1 || (kind_tab[idx] == 2'd2 && tk)) begin
          exp_pc = pd_pc_o + off_tab[idx];
        end else begin
          exp_pc = pd_pc_o + 32'd4;
        end
      end
      // Trap vector wins over branch unit
      if (st_flush_i) exp_pc = tr_vec_i;
      else if (bu_flush_i) exp_pc = bu_nxt_pc_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_flow: assert property (@(posedge clk) disable iff (!rst_n) consume |-> pd_pc_o == exp_pc)
    else report_mismatch($sformatf("pd_pc_o %h, expected %h", $sampled(pd_pc_o),
                                   $sampled(exp_pc)));

  a_word: assert property (@(posedge clk) disable iff (!rst_n)
                           consume |-> pd_insn_o.instr == exp_word)
    else report_mismatch($sformatf("instr %h at pc %h, expected %h",
                                   $sampled(pd_insn_o.instr), $sampled(pd_pc_o),
                                   $sampled(exp_word)));

  a_bp: assert property (@(posedge clk) disable iff (!rst_n)
                         consume && kind_tab[pd_pc_o[9:2]] != 2'd0 |->
                         pd_bp_predict_o == exp_bp)
    else report_mismatch($sformatf("prediction %b at pc %h, expected %b",
                                   $sampled(pd_bp_predict_o), $sampled(pd_pc_o),
                                   $sampled(exp_bp)));

  a_exc: assert property (@(posedge clk) disable iff (!rst_n)
                          consume |-> pd_exceptions_o ==
                          {pd_pc_o[9:2] == ERR_IDX[7:0], 1'b0})
    else report_mismatch($sformatf("exceptions %b at pc %h",
                                   $sampled(pd_exceptions_o), $sampled(pd_pc_o)));

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                           id_stall_i && !bu_flush_i && !st_flush_i |=>
                           $stable(pd_pc_o) && $stable(pd_insn_o))
    else report_mismatch("pre-decode word changed under stall");

  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
                            bu_flush_i || st_flush_i |=>
                            pd_insn_o.bubble && pd_exceptions_o == '0)
    else report_mismatch("no bubble after flush");

  a_ports: assert property (@(posedge clk) disable iff (!rst_n)
                            pd_stall_o == id_stall_i &&
                            pd_flush_o == (bu_flush_i || st_flush_i))
    else report_mismatch($sformatf("stall %b flush %b passed through as %b %b",
                                   $sampled(id_stall_i),
                                   $sampled(bu_flush_i || st_flush_i),
                                   $sampled(pd_stall_o), $sampled(pd_flush_o)));

  // rs1 and rs2 of the word on fe_o against the ROM word it came from
  a_regs: assert property (@(posedge clk) disable iff (!rst_n)
                           !id_stall_i |=> pd_insn_o.bubble ||
                           ($past(pd_rs1_o) == exp_word[19:15] &&
                            $past(pd_rs2_o) == exp_word[24:20]))
    else report_mismatch("rs1 or rs2 differs from the fetched word");

  a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                            pd_latch_nxt_pc_o |=> !pd_latch_nxt_pc_o)
    else report_mismatch("latch strobe longer than one cycle");

  // Strobed word moves on into pre-decode with the jump target
  a_target: assert property (@(posedge clk) disable iff (!rst_n)
                             pd_latch_nxt_pc_o && !id_stall_i && !bu_flush_i &&
                             !st_flush_i |=> !pd_insn_o.bubble &&
                             (kind_tab[pd_pc_o[9:2]] == 2'd1 ||
                              (kind_tab[pd_pc_o[9:2]] == 2'd2 && exp_bp[1])) &&
                             $past(pd_nxt_pc_o) == pd_pc_o + off_tab[pd_pc_o[9:2]])
    else report_mismatch($sformatf("latch strobe target wrong for pc %h",
                                   $sampled(pd_pc_o)));

  a_first_ar: assert property (@(posedge clk) disable iff (!rst_n)
                               arvalid_o && !ar_seen |-> ar_o.addr == PC_INIT)
    else report_mismatch("first read address is not the reset PC");

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
                              arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else report_failure("read request dropped or changed before it was accepted");

  // Unprivileged, secure, instruction access
  a_prot: assert property (@(posedge clk) disable iff (!rst_n)
                           arvalid_o |-> ar_o.prot == 3'b100)
    else report_mismatch($sformatf("read protection %b, expected 100",
                                   $sampled(ar_o.prot)));

  ////////////////////////////////////////////////////////////
  // Stimulus and report
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [31:0] r, s;
    mismatches = 0;
    other_errors = 0;
    cycles = 0;
    consumed = 0;
    err_seen = 0;
    id_stall_i = 1'b0;
    bu_flush_i = 1'b0;
    bu_nxt_pc_i = '0;
    bu_upd_i = 1'b0;
    bu_upd_pc_i = '0;
    bu_taken_i = 1'b0;
    st_flush_i = 1'b0;
    tr_vec_i = '0;
    ar_ok = 1'b1;
    r_ok = 1'b1;
    fill_rom();

    @(posedge rst_n);
    @(negedge clk);
    if (arvalid_o || pd_latch_nxt_pc_o || pd_flush_o || !pd_insn_o.bubble ||
        pd_exceptions_o != '0 || pd_pc_o != PC_INIT) begin
      report_failure("outputs after reset are not at their reset values");
    end

    // Flushes held off first so the start block reaches the error word
    for (int i = 0; i < RUN_CYCLES; i++) begin
      @(posedge clk);
      r = next_rand();
      s = next_rand();
      id_stall_i  <= r[1:0] == 2'b00;
      ar_ok       <= r[3:2] != 2'b00;
      r_ok        <= r[5:4] != 2'b00;
      bu_flush_i  <= i >= 100 && r[11:6] == 6'd0;
      bu_nxt_pc_i <= {22'h0, r[19:12], 2'b00};
      st_flush_i  <= i >= 100 && r[25:20] == 6'd0;
      tr_vec_i    <= {22'h0, 2'b11, s[5:0], 2'b00};
      bu_upd_i    <= s[8:6] == 3'd0;
      bu_upd_pc_i <= {22'h0, s[16:9], 2'b00};
      bu_taken_i  <= s[17];
    end

    @(posedge clk);
    id_stall_i <= 1'b0;
    bu_flush_i <= 1'b0;
    st_flush_i <= 1'b0;
    bu_upd_i   <= 1'b0;
    repeat (DRAIN_CYCLES) @(posedge clk);

    if (consumed < 200) report_failure("too few instructions reached pre-decode");
    if (err_seen == 0) report_failure("the error address was never fetched");

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/rv_fe_pkg.sv
hw/rv_fetch.sv
hw/rv_bht.sv
hw/rv_predecode.sv
hw/rv_frontend_top.sv
test/tb_clk_gen.sv
test/tb_axil_rom.sv
test/tb_rv_frontend.sv

// ==== Bender.yml ====
package:
  name: rv_frontend

sources:
  - files:
      - hw/rv_fe_pkg.sv
      - hw/rv_fetch.sv
      - hw/rv_bht.sv
      - hw/rv_predecode.sv
      - hw/rv_frontend_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_axil_rom.sv
      - test/tb_rv_frontend.sv
